//--- filelist.f
logic/sound_pkg.sv
logic/codec_config_seq.sv
logic/codec_i2c_writer.sv
logic/dsp_frame_serializer.sv
logic/sound_driver_top.sv
test/tb_clock_gen.sv
test/tb_sound_driver.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, keep the log and decide on it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_sound_driver -f filelist.f -o sim_sound_driver \
    && ./obj_dir/sim_sound_driver | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- test/tb_sound_driver.sv
// one codec model with switchable acks; a frame is checked when the next lr pulse arrives
module tb_sound_driver
    import sound_pkg::*;
();

    // --------------------
    // records between processes
    // --------------------
    typedef struct packed {
        logic [31:0] idx;       // frame number from 1 at the first lr pulse
        logic [31:0] data;      // ac_dat bits with the first on top
        logic [31:0] edges;     // rising bclk count
        logic [31:0] period;    // cycles to the next lr pulse
    } frame_rec_t;

    typedef struct packed {
        logic [31:0] idx;       // frame that should carry it
        logic [31:0] word;      // host word as written
    } expect_rec_t;

    logic        clk_12;
    logic        rst_n;
    logic        sample_wr;
    logic [31:0] sample_data;
    logic        ac_sclk;
    wire         ac_sdat;
    logic        ac_xclk;
    logic        ac_bclk;
    logic        ac_dat;
    logic        ac_lr;

    bit          ack_en;        // codec answers the ninth bit
    bit          ack_slot;      // inside a ninth-bit slot
    bit          sdat_probe;    // pulls sdat low to show the writer let go
    logic        sclk_q;
    logic        sdat_q;
    logic [7:0]  rx_byte;
    int          rx_bits;
    int          rx_bytes;
    logic [23:0] rx_txn;
    bit          in_txn;
    int          bad_txns;      // stop without start or without three bytes
    logic [23:0] txn_q[$];

    logic        lr_q;
    logic        bclk_q;
    int          cyc;
    int          frame_idx;
    int          frame_start;
    logic [31:0] cur_data;
    int          cur_edges;
    bit          early_frame;   // lr or bclk seen before setup ended
    frame_rec_t  done_q[$];
    expect_rec_t exp_q[$];
    int          frames_checked;

    int          checks;
    int          errors;
    int          tests;
    int          test_errors;   // error count when the running test began
    string       cur_test;

    tb_clock_gen u_clock_gen (
        .clk_12 (clk_12),
        .rst_n  (rst_n)
    );

    sound_driver_top uut (
        .clk_12      (clk_12),
        .rst_n       (rst_n),
        .sample_wr   (sample_wr),
        .sample_data (sample_data),
        .ac_sclk     (ac_sclk),
        .ac_sdat     (ac_sdat),
        .ac_xclk     (ac_xclk),
        .ac_bclk     (ac_bclk),
        .ac_dat      (ac_dat),
        .ac_lr       (ac_lr)
    );

    pullup (ac_sdat);                                           // board resistor
    assign ac_sdat = ((ack_en && ack_slot) || sdat_probe) ? 1'b0 : 1'bz;   // codec ack

    // left and right slot carry the same low half of the host word
    function automatic logic [31:0] expected_frame(input logic [31:0] host_word);
        return {host_word[15:0], host_word[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error in %s: %s", cur_test, what);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s finished, %0d errors", cur_test, errors - test_errors);
    endtask

    task automatic wait_lr_rise(input int limit, output bit seen);
        logic prev;
        int   n;
        prev = ac_lr;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(negedge clk_12);
            seen = ac_lr && !prev;
            prev = ac_lr;
            n++;
        end
    endtask

    task automatic wait_expect_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 500) begin
            @(negedge clk_12);
            n++;
        end
        if (exp_q.size() > 0) report_failure("written samples never reached ac_dat");
    endtask

    // write early in a frame so the sample rides on the following one
    task automatic send_sample(input logic [31:0] first, input logic [31:0] last,
                               input bit two_writes);
        bit          seen;
        expect_rec_t e;
        wait_lr_rise(300, seen);
        if (!seen) report_failure("no lr pulse before a sample write");
        @(negedge clk_12);                  // frame_idx settled by now
        e.idx  = frame_idx + 1;
        e.word = last;
        exp_q.push_back(e);
        if (two_writes) begin
            sample_wr   = 1'b1;
            sample_data = first;            // overwritten next cycle
            @(negedge clk_12);
        end
        sample_wr   = 1'b1;
        sample_data = last;
        @(negedge clk_12);
        sample_wr = 1'b0;
    endtask

    // --------------------
    // codec control bus model
    // --------------------
    always @(negedge clk_12) begin
        if (!rst_n) begin
            sclk_q   = 1'b1;
            sdat_q   = 1'b1;
            rx_bits  = 0;
            rx_bytes = 0;
            ack_slot = 1'b0;
            in_txn   = 1'b0;
        end else begin
            if (sclk_q && ac_sclk && sdat_q && !ac_sdat && !ack_slot) begin
                in_txn   = 1'b1;                // start
                rx_bits  = 0;
                rx_bytes = 0;
                rx_txn   = '0;
            end else if (sclk_q && ac_sclk && !sdat_q && ac_sdat) begin
                if (in_txn && rx_bytes == 3) txn_q.push_back(rx_txn);
                else bad_txns++;
                in_txn  = 1'b0;                 // stop
                rx_bits = 0;
            end else if (!sclk_q && ac_sclk && rx_bits < 8) begin
                rx_byte = {rx_byte[6:0], ac_sdat};  // data bit on rising sclk
                rx_bits++;
            end else if (sclk_q && !ac_sclk) begin
                if (ack_slot) begin             // end of ninth bit
                    ack_slot = 1'b0;
                    rx_bits  = 0;
                    rx_txn   = {rx_txn[15:0], rx_byte};
                    rx_bytes++;
                end else if (rx_bits == 8) begin
                    ack_slot = 1'b1;
                end
            end
            sclk_q = ac_sclk;
            sdat_q = ac_sdat;
        end
    end

    // --------------------
    // frame monitor and compare
    // --------------------
    always @(negedge clk_12) begin
        frame_rec_t rec;
        if (!rst_n) begin
            lr_q      = 1'b0;
            bclk_q    = 1'b0;
            frame_idx = 0;
        end else begin
            cyc++;
            if (ac_lr && !lr_q) begin
                if (frame_idx > 0) begin        // close the previous frame
                    rec.idx    = frame_idx;
                    rec.data   = cur_data;
                    rec.edges  = cur_edges;
                    rec.period = cyc - frame_start;
                    done_q.push_back(rec);
                end
                frame_idx++;
                cur_data    = '0;
                cur_edges   = 0;
                frame_start = cyc;
            end
            if (ac_bclk && !bclk_q) begin
                cur_data = {cur_data[30:0], ac_dat};
                cur_edges++;
            end
            if ((ac_lr || ac_bclk) && txn_q.size() < cfg_count) early_frame = 1'b1;
            lr_q   = ac_lr;
            bclk_q = ac_bclk;
        end
    end

    always @(negedge clk_12) begin
        frame_rec_t  f;
        expect_rec_t e;
        if (done_q.size() > 0) begin
            f = done_q.pop_front();
            frames_checked++;
            check_value("frame period", 32'd125, f.period);
            check_value("frame bclk edges", 32'd32, f.edges);
            if (exp_q.size() > 0 && exp_q[0].idx == f.idx) begin
                e = exp_q.pop_front();
                check_value(cur_test, expected_frame(e.word), f.data);
            end else if (exp_q.size() > 0 && exp_q[0].idx < f.idx) begin
                e = exp_q.pop_front();
                report_failure("the frame for a written sample was skipped");
            end
        end
    end

    // --------------------
    // test list
    // --------------------
    initial begin
        bit          seen;
        int          n;
        logic [31:0] word;
        logic [31:0] decoy;
        sample_wr   = 1'b0;
        sample_data = '0;
        ack_en      = 1'b0;     // codec silent at first
        sdat_probe  = 1'b0;
        void'($urandom(32'h3cb2_63f9));

        start_test("reset_state");
        repeat (2) @(negedge clk_12);   // still in reset
        check_value(cur_test, 32'b11000, {27'd0, ac_sclk, ac_sdat, ac_bclk, ac_lr, ac_dat});
        sdat_probe = 1'b1;              // a released line follows the probe
        @(negedge clk_12);
        check_value("reset_state sdat released", 32'd0, {31'd0, ac_sdat});
        sdat_probe = 1'b0;
        // master clock follows clk_12 in both phases
        @(posedge clk_12);
        #5;
        check_value("reset_state xclk high", 32'd1, {31'd0, ac_xclk});
        @(negedge clk_12);
        #5;
        check_value("reset_state xclk low", 32'd0, {31'd0, ac_xclk});
        n = 0;
        while (!rst_n && n < 50) begin
            @(negedge clk_12);
            n++;
        end
        if (!rst_n) report_failure("reset was never released");
        end_test();

        start_test("ack_stall");
        wait_lr_rise(2000, seen);
        if (seen) report_failure("frames started although no write was acknowledged");
        check_value("ack_stall transactions", 32'd0, txn_q.size());
        ack_en = 1'b1;          // stuck write resumes from here
        end_test();

        start_test("config_writes");
        n = 0;
        while (txn_q.size() < cfg_count && n < 3000) begin
            @(negedge clk_12);
            n++;
        end
        if (txn_q.size() < cfg_count) report_failure("configuration did not finish");
        for (int i = 0; i < cfg_count && i < txn_q.size(); i++) begin
            check_value($sformatf("config_writes write %0d", i),
                        {8'h0, codec_dev_byte, codec_cfg_table[i]}, {8'h0, txn_q[i]});
        end
        check_value("config_writes broken transactions", 32'd0, bad_txns);
        check_value("config_writes frames during setup", 32'd0, {31'd0, early_frame});
        end_test();

        start_test("frame_timing");
        n = 0;
        while (frames_checked < 4 && n < 1000) begin
            @(negedge clk_12);
            n++;
        end
        if (frames_checked < 4) report_failure("fewer than four frames were seen");
        check_value("frame_timing writes in total", cfg_count, txn_q.size());
        end_test();

        start_test("random_samples");
        for (int i = 0; i < 20; i++) begin
            word = $urandom();
            send_sample(word, word, 1'b0);
        end
        wait_expect_drain();
        end_test();

        start_test("double_write");
        decoy = $urandom();
        word  = decoy ^ 32'h0000_a5c3;  // low half always differs
        send_sample(decoy, word, 1'b1);
        wait_expect_drain();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
// free-running clock from time 0; reset is asserted once at start and never again
module tb_clock_gen (
    output logic clk_12,
    output logic rst_n
);

    initial begin
        clk_12 = 1'b0;
        forever #10 clk_12 = ~clk_12;   // period 20
    end

    // 8 rising edges in reset, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk_12);
        @(negedge clk_12);
        rst_n = 1'b1;
    end

endmodule

//--- logic/sound_driver_top.sv
// wm8731 driver, codec mclk is clk_12 itself; host strobe has no handshake or back-pressure
module sound_driver_top
    import sound_pkg::*;
(
    input  logic        clk_12,
    input  logic        rst_n,

    // host side
    input  logic        sample_wr,
    input  logic [31:0] sample_data,

    // codec control bus
    output logic        ac_sclk,
    inout  wire         ac_sdat,

    // codec audio interface
    output logic        ac_xclk,
    output logic        ac_bclk,
    output logic        ac_dat,
    output logic        ac_lr
);

    logic       cmd_start;
    logic       cmd_idle;
    codec_cmd_t cmd;
    logic       cfg_ready;  // gates the frame counter

    assign ac_xclk = clk_12;    // master clock straight through

    // --------------------
    // configuration path
    // --------------------
    codec_config_seq u_config_seq (
        .clk_12    (clk_12),
        .rst_n     (rst_n),
        .cmd_idle  (cmd_idle),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .cfg_ready (cfg_ready)
    );

    codec_i2c_writer u_i2c_writer (
        .clk_12    (clk_12),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .cmd_idle  (cmd_idle),
        .ac_sclk   (ac_sclk),
        .ac_sdat   (ac_sdat)
    );

    // --------------------
    // audio path
    // --------------------
    dsp_frame_serializer u_serializer (
        .clk_12      (clk_12),
        .rst_n       (rst_n),
        .cfg_ready   (cfg_ready),
        .sample_wr   (sample_wr),
        .sample_data (sample_data),
        .ac_bclk     (ac_bclk),
        .ac_lr       (ac_lr),
        .ac_dat      (ac_dat)
    );

endmodule

//--- logic/dsp_frame_serializer.sv
// mono 16-bit output in dsp mode b, sample_data[31:16] ignored, one holding register only
module dsp_frame_serializer
    import sound_pkg::*;
(
    input  logic        clk_12,
    input  logic        rst_n,
    input  logic        cfg_ready,      // codec set up, frames may run
    input  logic        sample_wr,      // host write strobe
    input  logic [31:0] sample_data,
    output logic        ac_bclk,
    output logic        ac_lr,
    output logic        ac_dat
);

    sample_t    sample_next;    // latest host write
    sample_t    shift;          // rotating, msb on ac_dat
    frame_cnt_t frame_cnt;
    logic       in_window;      // bit clock active

    assign in_window = (frame_cnt >= bclk_first) && (frame_cnt <= bclk_last);
    assign ac_dat    = shift[15];

    // --------------------
    // host side
    // --------------------
    always_ff @(posedge clk_12 or negedge rst_n) begin
        if (!rst_n) begin
            sample_next <= '0;
        end else if (sample_wr) begin
            sample_next <= sample_data[15:0];   // newer write wins
        end
    end

    // --------------------
    // frame timing
    // --------------------
    always_ff @(posedge clk_12 or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (!cfg_ready) begin
            frame_cnt <= '0;                    // parked until configured
        end else if (frame_cnt == frame_len - 7'd1) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 7'd1;
        end
    end

    always_ff @(posedge clk_12 or negedge rst_n) begin
        if (!rst_n) begin
            ac_lr   <= 1'b0;
            ac_bclk <= 1'b0;
        end else begin
            ac_lr   <= (frame_cnt == 7'd1) || (frame_cnt == 7'd2);  // two cycle frame sync
            ac_bclk <= in_window ? !ac_bclk : 1'b0;
        end
    end

    // --------------------
    // data
    // --------------------
    // load just before the window, then rotate on each falling bclk
    // so the full rotation repeats the sample for the right slot
    always_ff @(posedge clk_12 or negedge rst_n) begin
        if (!rst_n) begin
            shift <= '0;
        end else if (frame_cnt == 7'd1) begin
            shift <= sample_next;
        end else if (in_window && frame_cnt[0]) begin
            shift <= {shift[14:0], shift[15]};
        end
    end

endmodule

//--- logic/codec_i2c_writer.sv
// write-only two-wire master, two clk_12 cycles per bit; waits forever on a missing ack
module codec_i2c_writer
    import sound_pkg::*;
(
    input  logic       clk_12,
    input  logic       rst_n,
    input  logic       cmd_start,   // one cycle, only while cmd_idle
    input  codec_cmd_t cmd,
    output logic       cmd_idle,
    output logic       ac_sclk,
    inout  wire        ac_sdat      // open drain, pulled up on the board
);

    i2c_state_t state;
    logic       sdat_oe;    // high drives the line, low releases it
    logic       sdat_o;
    logic [7:0] dat_byte;   // byte being shifted, msb on the wire
    logic [2:0] bit_cnt;    // bits left after the current one
    logic [1:0] part;       // 0 device, 1 address, 2 data

    assign ac_sdat  = sdat_oe ? sdat_o : 1'bz;
    assign cmd_idle = (state == i2c_idle) && !cmd_start;

    always_ff @(posedge clk_12 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= i2c_idle;
            ac_sclk  <= 1'b1;   // bus idle, both lines high
            sdat_oe  <= 1'b0;
            sdat_o   <= 1'b1;
            dat_byte <= '0;
            bit_cnt  <= '0;
            part     <= '0;
        end else begin
            case (state)
                i2c_idle: begin
                    if (cmd_start) begin
                        // start, sdat falls while sclk is high
                        sdat_oe  <= 1'b1;
                        sdat_o   <= 1'b0;
                        ac_sclk  <= 1'b1;
                        dat_byte <= codec_dev_byte;
                        bit_cnt  <= 3'd7;
                        part     <= 2'd0;
                        state    <= i2c_send_lo;
                    end
                end

                // --------------------
                // byte shift
                // --------------------
                i2c_send_lo: begin
                    ac_sclk <= 1'b0;
                    sdat_oe <= 1'b1;
                    sdat_o  <= dat_byte[7];     // set up while clock low
                    state   <= i2c_send_hi;
                end
                i2c_send_hi: begin
                    ac_sclk <= 1'b1;            // codec samples here
                    if (bit_cnt == 3'd0) begin
                        state <= i2c_ack_lo;
                    end else begin
                        dat_byte <= {dat_byte[6:0], 1'b0};
                        bit_cnt  <= bit_cnt - 3'd1;
                        state    <= i2c_send_lo;
                    end
                end

                // --------------------
                // ninth bit
                // --------------------
                i2c_ack_lo: begin
                    ac_sclk <= 1'b0;
                    sdat_oe <= 1'b0;            // let the codec drive
                    state   <= i2c_ack_hi;
                end
                i2c_ack_hi: begin
                    ac_sclk <= 1'b1;
                    state   <= i2c_ack_wait;
                end
                i2c_ack_wait: begin
                    if (ac_sdat == 1'b0) begin  // acked, else sit here
                        ac_sclk <= 1'b0;
                        bit_cnt <= 3'd7;
                        part    <= part + 2'd1;
                        case (part)
                            2'd0:    dat_byte <= {cmd.reg_addr, cmd.reg_data[8]};
                            default: dat_byte <= cmd.reg_data[7:0];
                        endcase
                        state <= (part == 2'd2) ? i2c_stop_lo : i2c_send_lo;
                    end
                end

                // --------------------
                // stop, sdat rises while sclk is high
                // --------------------
                i2c_stop_lo: begin
                    ac_sclk <= 1'b0;
                    sdat_oe <= 1'b1;
                    sdat_o  <= 1'b0;
                    state   <= i2c_stop_hi;
                end
                i2c_stop_hi: begin
                    ac_sclk <= 1'b1;
                    state   <= i2c_stop_rel;
                end
                i2c_stop_rel: begin
                    sdat_oe <= 1'b0;            // pullup brings it high
                    state   <= i2c_idle;
                end

                default: state <= i2c_idle;
            endcase
        end
    end

endmodule

//--- logic/codec_config_seq.sv
// issues the eight codec writes once after reset; no retry, a missing ack stalls it for good
module codec_config_seq
    import sound_pkg::*;
(
    input  logic       clk_12,
    input  logic       rst_n,
    input  logic       cmd_idle,    // writer free, no start pending
    output logic       cmd_start,   // one cycle pulse
    output codec_cmd_t cmd,         // held until next start
    output logic       cfg_ready    // stays high until reset
);

    config_state_t state;
    config_state_t state_next;
    logic [$clog2(cfg_count)-1:0] cfg_idx;  // table entry for the next write
    logic issue;                            // advance this cycle
    logic load;                             // advance and start a write

    // --------------------
    // step order
    // --------------------
    always_comb begin
        case (state)
            cs_idle:     state_next = cs_reset;
            cs_reset:    state_next = cs_power;
            cs_power:    state_next = cs_output;
            cs_output:   state_next = cs_side;
            cs_side:     state_next = cs_emph;
            cs_emph:     state_next = cs_format;
            cs_format:   state_next = cs_sampling;
            cs_sampling: state_next = cs_activate;
            cs_activate: state_next = cs_ready;   // last write done
            default:     state_next = cs_ready;
        endcase
    end

    // first write goes out straight after reset, the rest wait for the writer
    always_comb begin
        case (state)
            cs_idle:  issue = 1'b1;
            cs_ready: issue = 1'b0;
            default:  issue = cmd_idle;
        endcase
    end

    assign load = issue && (state != cs_activate);  // activate step only finishes

    // --------------------
    // control state
    // --------------------
    always_ff @(posedge clk_12 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cs_idle;
            cmd_start <= 1'b0;
            cfg_idx   <= '0;
        end else begin
            cmd_start <= load;          // drops on its own after one cycle
            if (issue) begin
                state <= state_next;
            end
            if (load) begin
                cfg_idx <= cfg_idx + 1'b1;
            end
        end
    end

    // command word, only read by the writer after a start
    always_ff @(posedge clk_12) begin
        if (load) begin
            cmd <= codec_cfg_table[cfg_idx];
        end
    end

    assign cfg_ready = (state == cs_ready);

endmodule

//--- logic/sound_pkg.sv
// wm8731 settings fixed for dsp mode b, 12 mhz usb clocking, dac only; no runtime changes
package sound_pkg;

    // --------------------
    // widths with a meaning
    // --------------------
    typedef logic [15:0] sample_t;     // one pcm sample, signed, msb first
    typedef logic [6:0]  reg_addr_t;   // codec register address
    typedef logic [8:0]  reg_data_t;   // codec register value
    typedef logic [6:0]  frame_cnt_t;  // position inside one frame

    // two data bytes of a control write, address on top
    typedef struct packed {
        reg_addr_t reg_addr;
        reg_data_t reg_data;
    } codec_cmd_t;

    // configuration steps, one per register write
    typedef enum logic [3:0] {
        cs_idle,
        cs_reset,
        cs_power,
        cs_output,
        cs_side,
        cs_emph,
        cs_format,
        cs_sampling,
        cs_activate,
        cs_ready
    } config_state_t;

    // control bus writer
    typedef enum logic [3:0] {
        i2c_idle,
        i2c_send_lo,    // sclk low, data bit set up
        i2c_send_hi,    // sclk high, bit valid
        i2c_ack_lo,
        i2c_ack_hi,
        i2c_ack_wait,   // hold here until codec pulls sdat low
        i2c_stop_lo,
        i2c_stop_hi,
        i2c_stop_rel
    } i2c_state_t;

    // --------------------
    // codec setup
    // --------------------
    localparam logic [7:0] codec_dev_byte = 8'h34;  // 0x1a << 1, write
    localparam int cfg_count = 8;

    // write order matters: reset first, activate last
    localparam codec_cmd_t codec_cfg_table [cfg_count] = '{
        '{reg_addr: 7'h0F, reg_data: 9'h000},   // soft reset
        '{reg_addr: 7'h06, reg_data: 9'h067},   // power down adc, mic, line in
        '{reg_addr: 7'h02, reg_data: 9'h179},   // headphone 0 dB, both channels
        '{reg_addr: 7'h04, reg_data: 9'h0D2},   // dac select, bypass off
        '{reg_addr: 7'h05, reg_data: 9'h005},   // unmute, de-emphasis
        '{reg_addr: 7'h07, reg_data: 9'h003},   // dsp format, 16 bit, mode b
        '{reg_addr: 7'h08, reg_data: 9'h01D},   // usb mode 12 MHz, 96 kHz
        '{reg_addr: 7'h09, reg_data: 9'h001}    // activate interface
    };

    // --------------------
    // frame timing
    // --------------------
    localparam frame_cnt_t frame_len  = 7'd125;  // 12 MHz / 96 kHz
    localparam frame_cnt_t bclk_first = 7'd2;    // bclk toggles from here
    localparam frame_cnt_t bclk_last  = 7'd64;   // through here, 32 rising edges

endpackage
